//--- hdl/cache_pkg.sv
package cache_pkg;

    // data path
    localparam int WORD_W   = 32;
    localparam int BANKS    = 4;
    localparam int BANK_W   = 2;

    // address split
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL
    } cache_state_t;

    // field layout for the default 256-set geometry
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [7:0]          index;
        logic [OFFSET_W-1:0] offset;
    } cache_fields_t;

    // one address word, read either whole or by field
    typedef union packed {
        logic [31:0]   flat;
        cache_fields_t f;
    } cache_addr_t;

endpackage

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic valid,
    input  logic cache_hit,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    output logic addr_ok,
    output logic lookup_en,
    output logic refill_active,
    output logic fill_done,
    output logic data_ok,
    output logic rd_req
);

    cache_state_t state;
    cache_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = cache_hit ? IDLE : REPLACE;
            end
            // hold the read request until memory takes it
            REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (fill_done) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // one request in flight, so accept only when idle
    assign addr_ok       = (state == IDLE) && valid;
    assign lookup_en     = addr_ok;
    assign rd_req        = (state == REPLACE);
    assign refill_active = (state == REFILL);
    assign fill_done     = refill_active && ret_valid && ret_last;

    // hit answers from lookup, miss answers with the last beat
    assign data_ok = ((state == LOOKUP) && cache_hit) || fill_done;

endmodule

//--- hdl/refill_counter.sv
`timescale 1ns/1ps

module refill_counter import cache_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ret_valid,
    input  logic              ret_last,
    output logic [BANK_W-1:0] beat
);

    // beat number of the next word returned by memory
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (ret_valid && ret_last) begin
            beat <= '0;
        end else if (ret_valid) begin
            beat <= beat + 1'b1;
        end
    end

endmodule

//--- hdl/req_buffer.sv
`timescale 1ns/1ps

module req_buffer import cache_pkg::*; #(
    parameter int          INDEX_W   = 8,
    parameter logic [22:0] LFSR_SEED = 23'h4a528a
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                lookup_en,
    input  logic                rd_req,
    input  logic                rd_rdy,
    input  logic [INDEX_W-1:0]  index,
    input  logic [TAG_W-1:0]    tag,
    input  logic [OFFSET_W-1:0] offset,
    output cache_addr_t         req_addr,
    output logic                victim
);

    logic [22:0] lfsr;

    // request word, loaded on the accept strobe
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_addr.f.tag    <= tag;
            req_addr.f.index  <= index;
            req_addr.f.offset <= offset;
        end
    end

    // free running, taps 22 and 17
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
        end
    end

    // way choice frozen once the line read is taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            victim <= lfsr[0];
        end
    end

endmodule

//--- hdl/cache_way.sv
`timescale 1ns/1ps

module cache_way import cache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    lookup_en,
    input  logic [INDEX_W-1:0]      index,
    input  logic                    refill_we,
    input  logic                    fill_done,
    input  logic [INDEX_W-1:0]      req_index,
    input  logic [TAG_W-1:0]        req_tag,
    input  logic [BANK_W-1:0]       beat,
    input  logic [WORD_W-1:0]       ret_data,
    output logic                    hit_v,
    output logic [TAG_W-1:0]        way_tag,
    output logic [BANKS*WORD_W-1:0] bank_rdata
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0]    valid_bits;
    logic [TAG_W-1:0]   tag_mem [SETS];

    // valid bits start cleared so every line misses after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            hit_v      <= 1'b0;
        end else begin
            if (refill_we && fill_done) begin
                valid_bits[req_index] <= 1'b1;
            end
            if (lookup_en) begin
                hit_v <= valid_bits[index];
            end
        end
    end

    // tag written once the whole line is in
    always_ff @(posedge clk) begin
        if (refill_we && fill_done) begin
            tag_mem[req_index] <= req_tag;
        end
        if (lookup_en) begin
            way_tag <= tag_mem[index];
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic [WORD_W-1:0] mem [SETS];
        logic [WORD_W-1:0] rd_q;

        // refill writes one bank per beat
        always_ff @(posedge clk) begin
            if (refill_we && (beat == BANK_W'(b))) begin
                mem[req_index] <= ret_data;
            end
            if (lookup_en) begin
                rd_q <= mem[index];
            end
        end

        assign bank_rdata[b*WORD_W +: WORD_W] = rd_q;
    end

endmodule

//--- hdl/load_select.sv
`timescale 1ns/1ps

module load_select import cache_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    way0_v,
    input  logic [TAG_W-1:0]        way0_tag,
    input  logic [BANKS*WORD_W-1:0] way0_banks,
    input  logic                    way1_v,
    input  logic [TAG_W-1:0]        way1_tag,
    input  logic [BANKS*WORD_W-1:0] way1_banks,
    input  logic [TAG_W-1:0]        req_tag,
    input  logic [BANK_W-1:0]       req_bank,
    input  logic [BANK_W-1:0]       beat,
    input  logic [WORD_W-1:0]       ret_data,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  logic                    refill_active,
    output logic                    cache_hit,
    output logic [WORD_W-1:0]       rdata
);

    logic              way0_hit;
    logic              way1_hit;
    logic [WORD_W-1:0] way0_word;
    logic [WORD_W-1:0] way1_word;
    logic [WORD_W-1:0] hit_word;
    logic [WORD_W-1:0] miss_word;
    logic              last_beat;

    assign way0_hit  = way0_v && (way0_tag == req_tag);
    assign way1_hit  = way1_v && (way1_tag == req_tag);
    assign cache_hit = way0_hit || way1_hit;

    assign way0_word = way0_banks[req_bank*WORD_W +: WORD_W];
    assign way1_word = way1_banks[req_bank*WORD_W +: WORD_W];
    assign hit_word  = way1_hit ? way1_word : way0_word;

    // keep the requested word as it streams past
    always_ff @(posedge clk) begin
        if (!resetn) begin
            miss_word <= '0;
        end else if (refill_active && ret_valid && (beat == req_bank)) begin
            miss_word <= ret_data;
        end
    end

    assign last_beat = refill_active && ret_valid && ret_last;

    // bank 3 arrives with the last beat itself
    always_comb begin
        if (!last_beat) begin
            rdata = hit_word;
        end else if (req_bank == BANK_W'(BANKS - 1)) begin
            rdata = ret_data;
        end else begin
            rdata = miss_word;
        end
    end

endmodule

//--- hdl/cache.sv
`timescale 1ns/1ps

module cache import cache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic [INDEX_W-1:0]  index,
    input  logic [TAG_W-1:0]    tag,
    input  logic [OFFSET_W-1:0] offset,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    output logic                rd_req,
    output logic [2:0]          rd_type,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [WORD_W-1:0]   ret_data
);

    logic                    lookup_en;
    logic                    refill_active;
    logic                    fill_done;
    logic                    cache_hit;
    logic [BANK_W-1:0]       beat;
    cache_addr_t             req_addr;
    logic                    victim;
    logic                    way0_we;
    logic                    way1_we;
    logic                    way0_v;
    logic                    way1_v;
    logic [TAG_W-1:0]        way0_tag;
    logic [TAG_W-1:0]        way1_tag;
    logic [BANKS*WORD_W-1:0] way0_banks;
    logic [BANKS*WORD_W-1:0] way1_banks;

    // cache-row read of the whole line
    assign rd_type = 3'b100;
    assign rd_addr = {req_addr.flat[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign way0_we = refill_active && ret_valid && !victim;
    assign way1_we = refill_active && ret_valid && victim;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .cache_hit     (cache_hit),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .addr_ok       (addr_ok),
        .lookup_en     (lookup_en),
        .refill_active (refill_active),
        .fill_done     (fill_done),
        .data_ok       (data_ok),
        .rd_req        (rd_req)
    );

    refill_counter u_beat (
        .clk       (clk),
        .resetn    (resetn),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .beat      (beat)
    );

    req_buffer #(
        .INDEX_W (INDEX_W)
    ) u_req (
        .clk       (clk),
        .resetn    (resetn),
        .lookup_en (lookup_en),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .req_addr  (req_addr),
        .victim    (victim)
    );

    cache_way #(
        .INDEX_W (INDEX_W)
    ) way0 (
        .clk        (clk),
        .resetn     (resetn),
        .lookup_en  (lookup_en),
        .index      (index),
        .refill_we  (way0_we),
        .fill_done  (fill_done),
        .req_index  (req_addr.f.index),
        .req_tag    (req_addr.f.tag),
        .beat       (beat),
        .ret_data   (ret_data),
        .hit_v      (way0_v),
        .way_tag    (way0_tag),
        .bank_rdata (way0_banks)
    );

    cache_way #(
        .INDEX_W (INDEX_W)
    ) way1 (
        .clk        (clk),
        .resetn     (resetn),
        .lookup_en  (lookup_en),
        .index      (index),
        .refill_we  (way1_we),
        .fill_done  (fill_done),
        .req_index  (req_addr.f.index),
        .req_tag    (req_addr.f.tag),
        .beat       (beat),
        .ret_data   (ret_data),
        .hit_v      (way1_v),
        .way_tag    (way1_tag),
        .bank_rdata (way1_banks)
    );

    load_select u_load (
        .clk           (clk),
        .resetn        (resetn),
        .way0_v        (way0_v),
        .way0_tag      (way0_tag),
        .way0_banks    (way0_banks),
        .way1_v        (way1_v),
        .way1_tag      (way1_tag),
        .way1_banks    (way1_banks),
        .req_tag       (req_addr.f.tag),
        .req_bank      (req_addr.f.offset[OFFSET_W-1 -: BANK_W]),
        .beat          (beat),
        .ret_data      (ret_data),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .refill_active (refill_active),
        .cache_hit     (cache_hit),
        .rdata         (rdata)
    );

endmodule

//--- test/mem_responder.sv
`timescale 1ns/1ps

module mem_responder (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    input  logic [3:0]  rdy_wait,
    input  logic [7:0]  beat_gap,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output logic [31:0] ret_data
);

    logic [31:0] line;

    // memory contents for a line-aligned address and bank
    function automatic logic [31:0] line_word(input logic [31:0] base, input int b);
        return base ^ (32'(b) * 32'h01010101) ^ 32'h5a5a0000;
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (resetn && rd_req) begin
                line = rd_addr;
                // back-pressure before taking the request
                repeat (rdy_wait) begin
                    @(posedge clk);
                    #1;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    repeat (beat_gap[2*b +: 2]) begin
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = line_word(line, b);
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

//--- test/tb_cache.sv
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    localparam logic [31:0] SEED = 32'h17c5705e;
    localparam int N_REQ = 311;
    localparam int CYCLE_LIMIT = 200 * N_REQ;

    logic clk = 1'b0;
    logic resetn, valid, addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last;
    logic [7:0]          index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic [WORD_W-1:0]   rdata, ret_data;
    logic [2:0]          rd_type;
    logic [31:0]         rd_addr, acc_addr, line;
    logic [3:0]          rdy_wait;
    logic [7:0]          beat_gap;
    logic [TAG_W-1:0]    tags [3];
    logic expect_hit, expect_miss, pending, went_out, rst_q;
    int   min_wait, n_acc, n_done, n_tests, mark, cycles;
    int   errors = 0;

    always #20 clk = ~clk;

    cache u_cache (
        .clk(clk), .resetn(resetn), .valid(valid), .index(index), .tag(tag),
        .offset(offset), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data)
    );

    mem_responder u_mem (
        .clk(clk), .resetn(resetn), .rd_req(rd_req), .rd_addr(rd_addr),
        .rdy_wait(rdy_wait), .beat_gap(beat_gap), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data)
    );

    // memory word rule with the bank from offset bits 3:2
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:4], 4'h0} ^ (32'(addr[3:2]) * 32'h01010101) ^ 32'h5a5a0000;
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // accepted request and its progress
    always @(posedge clk) begin
        rst_q <= resetn;
        if (!resetn) begin
            pending  <= 1'b0;
            went_out <= 1'b0;
            n_acc    <= 0;
            n_done   <= 0;
        end else begin
            if (valid && addr_ok) begin
                acc_addr <= {tag, index, offset};
                pending  <= 1'b1;
                went_out <= 1'b0;
                n_acc    <= n_acc + 1;
            end
            if (rd_req) begin
                went_out <= 1'b1;
            end
            if (data_ok) begin
                pending <= 1'b0;
                n_done  <= n_done + 1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) resetn && !rst_q |-> !addr_ok && !data_ok && !rd_req)
        else log_mismatch("handshake outputs not low after reset");
    a_idle: assert property (@(posedge clk) disable iff (!resetn) !valid |-> !addr_ok)
        else log_mismatch("addr_ok high without valid");
    a_miss: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && expect_miss |-> ##2 rd_req)
        else log_mismatch("first read did not raise rd_req");
    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == {acc_addr[31:4], 4'h0} && rd_type == 3'b100)
        else log_mismatch("wrong rd_addr or rd_type");
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else log_mismatch("read request dropped or changed before rd_rdy");
    a_quiet: assert property (@(posedge clk) disable iff (!resetn) rd_req |-> !data_ok && !addr_ok)
        else log_mismatch("data_ok or addr_ok during read request");
    a_hit: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && expect_hit |=> data_ok && !rd_req)
        else log_mismatch("hit not answered one cycle after acceptance");
    a_data: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> rdata == expected_word(acc_addr))
        else log_mismatch($sformatf("rdata %h for address %h", rdata, acc_addr));
    a_once: assert property (@(posedge clk) disable iff (!resetn) data_ok |-> pending)
        else log_mismatch("data_ok without an open request");
    a_last: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && went_out |-> ret_valid && ret_last)
        else log_mismatch("miss answered before the last beat");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // one request from drive to data_ok
    task automatic read_word(input logic [31:0] addr, input logic hit, input logic miss);
        valid       = 1'b1;
        tag         = addr[31:12];
        index       = addr[11:4];
        offset      = addr[3:0];
        expect_hit  = hit;
        expect_miss = miss;
        rdy_wait    = 4'($urandom_range(min_wait + 6, min_wait));
        beat_gap    = 8'($urandom);
        #1;
        while (!addr_ok) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        // request stays offered while the cache is busy
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        while (pending) begin
            @(posedge clk);
            #1;
        end
        valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %0d %s: %0d failures", n_tests, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        void'($urandom(SEED));
        cycles = 0;
        n_tests = 0;
        mark = 0;
        min_wait = 0;
        resetn = 1'b0;
        valid = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        expect_hit = 1'b0;
        expect_miss = 1'b0;
        rdy_wait = '0;
        beat_gap = '0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        end_test("reset");

        for (int i = 0; i < 2; i++) begin
            line = {20'($urandom), 8'(8'h10 + i), 4'h0};
            read_word(line | 32'($urandom_range(15, 0)), 1'b0, 1'b1);
            for (int w = 0; w < 4; w++) begin
                read_word(line + 32'(4 * w), 1'b1, 1'b0);
            end
            end_test("line miss and re-read");
        end

        min_wait = 8;
        read_word({20'($urandom), 8'h20, 4'h8}, 1'b0, 1'b1);
        min_wait = 0;
        end_test("read back-pressure");

        // three tags fighting over two sets of two ways
        for (int i = 0; i < 3; i++) begin
            tags[i] = {18'($urandom), 2'(i)};
        end
        repeat (300) begin
            line = {tags[$urandom_range(2, 0)], 8'h40, 4'($urandom)};
            line[4] = 1'($urandom);
            read_word(line, 1'b0, 1'b0);
        end
        end_test("random reads");

        repeat (2) begin
            @(posedge clk);
            #1;
        end
        if (n_done != n_acc) begin
            $display("data_ok was seen %0d times for %0d accepted requests", n_done, n_acc);
            errors++;
        end
        $display("%0d tests, %0d requests, %0d failures", n_tests, n_acc, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/refill_counter.sv
hdl/req_buffer.sv
hdl/cache_way.sv
hdl/load_select.sv
hdl/cache.sv
test/mem_responder.sv
test/tb_cache.sv
